//--- Makefile
# Verilator build of the cache lookup stage testbench

VERILATOR ?= verilator
TOP       ?= cache_stage_tb
FLIST     ?= cache_stage.f
BUILD     ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Simulation passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)

run: compile
	@./$(BUILD)/V$(TOP) | tee /dev/stderr | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(BUILD)

//--- bench/cache_checker.sv
`timescale 1ns/100ps
`default_nettype none

`include "cache_defines.svh"

module cache_checker (
    input wire                   clk,
    input wire                   reset,
    input wire                   req_valid,
    input wire                   req_write,
    input wire cache_pkg::addr_t req_addr,
    input wire cache_pkg::line_t req_data,
    input wire cache_pkg::mask_t req_mask,
    input wire                   stall,
    input wire                   resp_valid,
    input wire                   resp_hit,
    input wire cache_pkg::line_t resp_line,
    input wire                   wb_valid,
    input wire cache_pkg::addr_t wb_addr,
    input wire cache_pkg::line_t wb_line,
    input wire                   fill_req,
    input wire cache_pkg::addr_t fill_addr,
    input wire                   fill_valid,
    input wire cache_pkg::line_t fill_line,
    input wire                   bus_error
);

    cache_pkg::tag_t  tags  [`CACHE_SETS][`CACHE_WAYS];
    logic             valid [`CACHE_SETS][`CACHE_WAYS];
    logic             dirty [`CACHE_SETS][`CACHE_WAYS];
    cache_pkg::age_t  age   [`CACHE_SETS][`CACHE_WAYS];
    // Memory as the requester sees it, keyed by line address
    cache_pkg::line_t view  [cache_pkg::addr_t];

    int               phase;
    int               cyc;
    int               miss_cyc;
    int               fill_cyc;
    int               set_n;
    int               way_n;
    int               victim;
    logic             wb_exp;
    logic             fill_out;
    logic             err_seen;
    logic             resp_exp;
    logic             exp_hit;
    cache_pkg::line_t exp_line;
    cache_pkg::addr_t key;
    cache_pkg::addr_t victim_key;

    int    errors = 0;
    int    checks = 0;
    int    tests = 0;
    int    test_errors = 0;
    string test_name = "reset";

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        tests++;
        $display("test %s: %s (%0d errors)", test_name, test_errors ? "FAIL" : "ok", test_errors);
    endtask

    task automatic check_value(input string what, input logic [127:0] exp,
                               input logic [127:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            test_errors++;
            $display("CHECK FAILED %s %s: expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic problem(input string msg);
        errors++;
        test_errors++;
        $display("ERROR in %s at cycle %0d: %s", test_name, cyc, msg);
    endtask

    function automatic int find_way(input int s, input cache_pkg::tag_t t);
        find_way = -1;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (valid[s][w] && tags[s][w] == t) begin
                find_way = w;
            end
        end
    endfunction

    task automatic touch_way(input int s, input int w);
        cache_pkg::age_t old;
        old = age[s][w];
        for (int i = 0; i < `CACHE_WAYS; i++) begin
            if (i == w) begin
                age[s][i] = 0;
            end else if (age[s][i] < old) begin
                age[s][i] = age[s][i] + 1'b1;
            end
        end
    endtask

    // Accepted access against a line the model holds
    task automatic do_access(input logic hit_flag);
        exp_line = view.exists(key) ? view[key] : '0;
        if (!view.exists(key)) begin
            problem("access to a line never filled");
        end
        if (req_write) begin
            for (int b = 0; b < 16; b++) begin
                if (req_mask[b]) begin
                    exp_line[b*8 +: 8] = req_data[b*8 +: 8];
                end
            end
            view[key] = exp_line;
            dirty[set_n][way_n] = 1'b1;
        end
        touch_way(set_n, way_n);
        resp_exp = 1'b1;
        exp_hit  = hit_flag;
    endtask

    always @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                for (int w = 0; w < `CACHE_WAYS; w++) begin
                    valid[s][w] = 1'b0;
                    dirty[s][w] = 1'b0;
                    age[s][w]   = cache_pkg::age_t'(w);
                end
            end
            phase    = 0;
            cyc      = 0;
            fill_out = 1'b0;
            err_seen = 1'b0;
            resp_exp = 1'b0;
        end else begin
            cyc++;
            if (resp_exp) begin
                if (!resp_valid) begin
                    problem("no response one cycle after acceptance");
                end else begin
                    check_value("resp_hit", exp_hit, resp_hit);
                    check_value("resp_line", exp_line, resp_line);
                end
            end else if (resp_valid) begin
                problem("response without an accepted request");
            end
            resp_exp = 1'b0;

            if (fill_out && cyc - fill_cyc == `FILL_TIMEOUT && !bus_error) begin
                problem("bus_error did not rise on time");
            end
            if (bus_error && !err_seen) begin
                err_seen = 1'b1;
                if (!(fill_out && cyc - fill_cyc == `FILL_TIMEOUT)) begin
                    problem("bus_error rose at the wrong time");
                end
            end

            set_n = req_addr[5:4];
            key   = {req_addr[14:4], 4'b0000};
            way_n = find_way(set_n, req_addr[14:6]);
            if (phase != 1 && (wb_valid || fill_req || fill_valid)) begin
                problem("memory traffic without a pending miss");
            end
            if (phase == 0 && req_valid) begin
                if (way_n >= 0) begin
                    if (stall) begin
                        problem("stall on a hit");
                    end else begin
                        do_access(1'b1);
                    end
                end else begin
                    if (!stall) begin
                        problem("no stall on a miss");
                    end
                    victim = -1;
                    for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
                        if (!valid[set_n][w]) begin
                            victim = w;
                        end
                    end
                    for (int w = 0; w < `CACHE_WAYS; w++) begin
                        if (victim < 0 && age[set_n][w] == `CACHE_WAYS - 1) begin
                            victim = w;
                        end
                    end
                    wb_exp     = valid[set_n][victim] && dirty[set_n][victim];
                    victim_key = {tags[set_n][victim], req_addr[5:4], 4'b0000};
                    miss_cyc   = cyc;
                    phase      = 1;
                end
            end else if (phase == 0 && stall) begin
                problem("stall with no miss pending");
            end else if (phase == 1) begin
                if (!stall) begin
                    problem("stall dropped during a miss");
                end
                if (wb_valid != (wb_exp && cyc == miss_cyc + 1)) begin
                    problem("wb_valid does not match the predicted victim");
                end else if (wb_valid) begin
                    check_value("wb_addr", victim_key, wb_addr);
                    check_value("wb_line", view[victim_key], wb_line);
                end
                if (fill_req != (cyc == miss_cyc + 1 + int'(wb_exp))) begin
                    problem("fill_req in the wrong cycle");
                end else if (fill_req) begin
                    check_value("fill_addr", key, fill_addr);
                    fill_out = 1'b1;
                    fill_cyc = cyc;
                end
                if (fill_valid && fill_out) begin
                    if (view.exists(key)) begin
                        check_value("fill_line", view[key], fill_line);
                    end else begin
                        view[key] = fill_line;
                    end
                    fill_out             = 1'b0;
                    tags[set_n][victim]  = req_addr[14:6];
                    valid[set_n][victim] = 1'b1;
                    dirty[set_n][victim] = 1'b0;
                    touch_way(set_n, victim);
                    phase = 2;
                end
            end else if (phase == 2) begin
                if (stall || !req_valid || way_n < 0) begin
                    problem("held request not replayed as a hit");
                end else begin
                    do_access(1'b0);
                end
                phase = 0;
            end
        end
    end

endmodule

`default_nettype wire

//--- bench/cache_stage_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "cache_defines.svh"

module cache_stage_tb;

    localparam int RANDOM_REQS = 400;
    localparam int WORST_MISS  = 16;
    localparam int WATCHDOG_CYCLES = (32 + RANDOM_REQS) * WORST_MISS + `FILL_TIMEOUT + 100;

    logic             clk;
    logic             reset;
    logic             req_valid;
    logic             req_write;
    cache_pkg::addr_t req_addr;
    cache_pkg::line_t req_data;
    cache_pkg::mask_t req_mask;
    logic             fill_valid;
    cache_pkg::line_t fill_line;
    wire              stall;
    wire              resp_valid;
    wire              resp_hit;
    wire cache_pkg::line_t resp_line;
    wire              wb_valid;
    wire cache_pkg::addr_t wb_addr;
    wire cache_pkg::line_t wb_line;
    wire              fill_req;
    wire cache_pkg::addr_t fill_addr;
    wire              bus_error;

    // Backing memory, 8 tags by 4 sets
    cache_pkg::line_t backing [32];
    logic [15:0]      lfsr = 16'd37;
    logic             fill_pending = 1'b0;
    logic [2:0]       fill_wait;
    cache_pkg::addr_t pending_addr;
    logic             withhold = 1'b0;
    logic             withheld = 1'b0;

    cache_stage cache_stage_i (.*);

    cache_checker checker_i (.*);

    // Taps 16, 14, 13, 11
    function automatic logic [127:0] random_bits(input int n);
        random_bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr        = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            random_bits = {random_bits[126:0], lfsr[0]};
        end
    endfunction

    function automatic int line_of(input cache_pkg::addr_t a);
        return {a[14:12], a[5:4]};
    endfunction

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        for (int i = 0; i < 32; i++) begin
            for (int b = 0; b < 16; b++) begin
                backing[i][b*8 +: 8] = 8'(i * 29 + b * 7 + 8'h5a);
            end
        end
    end

    // Memory side: writebacks, delayed fills, one withheld fill
    always @(posedge clk) begin
        fill_valid <= 1'b0;
        if (wb_valid) begin
            backing[line_of(wb_addr)] = wb_line;
        end
        if (fill_pending) begin
            if (fill_wait == 0) begin
                fill_valid   <= 1'b1;
                fill_line    <= backing[line_of(pending_addr)];
                fill_pending = 1'b0;
            end else begin
                fill_wait = fill_wait - 1'b1;
            end
        end
        if (fill_req) begin
            if (withhold) begin
                withhold = 1'b0;
                withheld = 1'b1;
            end else begin
                fill_pending = 1'b1;
                pending_addr = fill_addr;
                fill_wait    = 3'(random_bits(3));
            end
        end
    end

    task automatic issue(input logic write, input logic [2:0] tag_sel, input logic [1:0] set,
                         input cache_pkg::line_t data, input cache_pkg::mask_t mask);
        req_valid <= 1'b1;
        req_write <= write;
        req_addr  <= {tag_sel, 6'b000000, set, 4'(random_bits(4))};
        req_data  <= data;
        req_mask  <= mask;
        @(posedge clk);
        while (stall && !withheld) begin
            @(posedge clk);
        end
    endtask

    task automatic issue_random();
        logic             write;
        logic [2:0]       tag_sel;
        logic [1:0]       set;
        cache_pkg::line_t data;
        cache_pkg::mask_t mask;
        write   = 1'(random_bits(1));
        tag_sel = 3'(random_bits(3));
        set     = 2'(random_bits(2));
        data    = random_bits(128);
        mask    = 16'(random_bits(16));
        issue(write, tag_sel, set, data, mask);
    endtask

    task automatic settle();
        req_valid <= 1'b0;
        repeat (3) @(posedge clk);
    endtask

    initial begin
        int waited;
        reset      = 1'b1;
        req_valid  = 1'b0;
        req_write  = 1'b0;
        req_addr   = '0;
        req_data   = '0;
        req_mask   = '0;
        fill_valid = 1'b0;
        fill_line  = '0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        checker_i.start_test("cold_reads");
        for (int t = 0; t < 8; t++) begin
            for (int s = 0; s < 4; s++) begin
                issue(1'b0, 3'(t), 2'(s), '0, '0);
            end
        end
        settle();
        checker_i.finish_test();

        checker_i.start_test("random_mix");
        for (int n = 0; n < RANDOM_REQS; n++) begin
            issue_random();
        end
        settle();
        checker_i.finish_test();

        checker_i.start_test("fill_timeout");
        withhold = 1'b1;
        while (!withheld) begin
            issue_random();
        end
        waited = 0;
        while (!bus_error && waited < `FILL_TIMEOUT + 8) begin
            @(posedge clk);
            waited++;
        end
        if (!bus_error) begin
            checker_i.problem("bus_error never rose after the withheld fill");
        end
        repeat (2) @(posedge clk);
        checker_i.finish_test();

        $display("tests %0d, checks %0d, errors %0d",
                 checker_i.tests, checker_i.checks, checker_i.errors);
        if (checker_i.errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- cache_stage.f
+incdir+design
design/cache_pkg.sv
design/cache_array.sv
design/tag_store.sv
design/line_store.sv
design/meta_store.sv
design/miss_controller.sv
design/bus_timer.sv
design/cache_stage.sv
bench/cache_checker.sv
bench/cache_stage_tb.sv

//--- design/bus_timer.sv
`timescale 1ns/100ps
`default_nettype none

`include "cache_defines.svh"

module bus_timer (
    input  wire  clk,
    input  wire  reset,
    input  wire  start,
    input  wire  stop,
    output logic timeout
);

    localparam int COUNT_W = $clog2(`FILL_TIMEOUT);
    localparam int LIMIT   = `FILL_TIMEOUT - 1;

    logic               busy;
    logic [COUNT_W-1:0] count;

    // count holds the cycles elapsed since start
    always_ff @(posedge clk) begin
        if (reset) begin
            busy    <= 1'b0;
            count   <= '0;
            timeout <= 1'b0;
        end else if (start) begin
            busy  <= 1'b1;
            count <= COUNT_W'(1);
        end else if (busy) begin
            if (stop) begin
                busy <= 1'b0;
            end else if (count == COUNT_W'(LIMIT)) begin
                busy    <= 1'b0;
                timeout <= 1'b1;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/cache_array.sv
`timescale 1ns/100ps
`default_nettype none

`include "cache_defines.svh"

module cache_array #(
    parameter type payload_t = logic [7:0]
) (
    input  wire                      clk,
    input  wire                      reset,
    input  wire cache_pkg::index_t   index,
    output payload_t                 rd_data [`CACHE_WAYS],
    input  wire                      we,
    input  wire cache_pkg::way_t     wr_way,
    input  wire payload_t            wr_data
);

    payload_t mem [`CACHE_SETS][`CACHE_WAYS];

    // All ways of the addressed set
    always_comb begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            rd_data[w] = mem[index][w];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                for (int w = 0; w < `CACHE_WAYS; w++) begin
                    mem[s][w] <= '0;
                end
            end
        end else if (we) begin
            mem[index][wr_way] <= wr_data;
        end
    end

endmodule

`default_nettype wire

//--- design/cache_defines.svh
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// Cache geometry
`define CACHE_WAYS 4
`define CACHE_SETS 4
`define LINE_BYTES 16

// Address layout: tag 14..6, index 5..4, offset 3..0
`define ADDR_TAG_LSB   6
`define ADDR_INDEX_LSB 4

// Cycles allowed between fill request and fill return
`define FILL_TIMEOUT 64

`endif

//--- design/cache_pkg.sv
`default_nettype none

package cache_pkg;

    // Address fields
    typedef logic [8:0]  tag_t;
    typedef logic [1:0]  index_t;
    typedef logic [14:0] addr_t;

    // Way number and true-LRU age, 0 is most recent
    typedef logic [1:0]  way_t;
    typedef logic [1:0]  age_t;

    // Line payload and its byte enables
    typedef logic [127:0] line_t;
    typedef logic [15:0]  mask_t;

endpackage

`default_nettype wire

//--- design/cache_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "cache_defines.svh"

module cache_stage (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      req_valid,
    input  wire                      req_write,
    input  wire cache_pkg::addr_t    req_addr,
    input  wire cache_pkg::line_t    req_data,
    input  wire cache_pkg::mask_t    req_mask,
    output wire                      stall,
    output wire                      resp_valid,
    output wire                      resp_hit,
    output wire cache_pkg::line_t    resp_line,
    output wire                      wb_valid,
    output wire cache_pkg::addr_t    wb_addr,
    output wire cache_pkg::line_t    wb_line,
    output wire                      fill_req,
    output wire cache_pkg::addr_t    fill_addr,
    input  wire                      fill_valid,
    input  wire cache_pkg::line_t    fill_line,
    output wire                      bus_error
);

    wire cache_pkg::tag_t   req_tag;
    wire cache_pkg::index_t index;
    wire cache_pkg::tag_t   way_tags [`CACHE_WAYS];
    wire [`CACHE_WAYS-1:0]  hit_vec;
    wire [`CACHE_WAYS-1:0]  valid_bits;
    wire cache_pkg::way_t   victim_way;
    wire cache_pkg::way_t   sel_way;
    wire                    victim_dirty;
    wire                    timer_start;
    wire                    tag_we;
    wire                    fill_we;
    wire                    merge_we;
    wire                    touch;
    wire                    install;
    wire                    set_dirty;

    assign req_tag = req_addr[`ADDR_TAG_LSB +: $bits(cache_pkg::tag_t)];
    assign index   = req_addr[`ADDR_INDEX_LSB +: $bits(cache_pkg::index_t)];

    // Line addresses, offset zero
    assign wb_addr   = {way_tags[victim_way], index, 4'b0000};
    assign fill_addr = {req_tag, index, 4'b0000};

    tag_store tag_store_i (
        .clk        (clk),
        .reset      (reset),
        .index      (index),
        .req_tag    (req_tag),
        .valid_bits (valid_bits),
        .we         (tag_we),
        .wr_way     (sel_way),
        .hit_vec    (hit_vec),
        .way_tags   (way_tags)
    );

    line_store line_store_i (
        .clk         (clk),
        .reset       (reset),
        .index       (index),
        .way         (sel_way),
        .fill_we     (fill_we),
        .fill_line   (fill_line),
        .merge_we    (merge_we),
        .req_data    (req_data),
        .req_mask    (req_mask),
        .sel_line    (wb_line),
        .merged_line (resp_line)
    );

    meta_store meta_store_i (
        .clk          (clk),
        .reset        (reset),
        .index        (index),
        .way          (sel_way),
        .touch        (touch),
        .install      (install),
        .set_dirty    (set_dirty),
        .valid_bits   (valid_bits),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty)
    );

    miss_controller miss_controller_i (
        .clk          (clk),
        .reset        (reset),
        .req_valid    (req_valid),
        .req_write    (req_write),
        .hit_vec      (hit_vec),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .fill_valid   (fill_valid),
        .stall        (stall),
        .accept       (),
        .resp_valid   (resp_valid),
        .resp_hit     (resp_hit),
        .wb_valid     (wb_valid),
        .fill_req     (fill_req),
        .timer_start  (timer_start),
        .tag_we       (tag_we),
        .fill_we      (fill_we),
        .merge_we     (merge_we),
        .touch        (touch),
        .install      (install),
        .set_dirty    (set_dirty),
        .sel_way      (sel_way)
    );

    bus_timer bus_timer_i (
        .clk     (clk),
        .reset   (reset),
        .start   (timer_start),
        .stop    (fill_valid),
        .timeout (bus_error)
    );

endmodule

`default_nettype wire

//--- design/line_store.sv
`timescale 1ns/100ps
`default_nettype none

`include "cache_defines.svh"

module line_store (
    input  wire                      clk,
    input  wire                      reset,
    input  wire cache_pkg::index_t   index,
    input  wire cache_pkg::way_t     way,
    input  wire                      fill_we,
    input  wire cache_pkg::line_t    fill_line,
    input  wire                      merge_we,
    input  wire cache_pkg::line_t    req_data,
    input  wire cache_pkg::mask_t    req_mask,
    output cache_pkg::line_t         sel_line,
    output cache_pkg::line_t         merged_line
);

    cache_pkg::line_t rd_lines [`CACHE_WAYS];
    cache_pkg::line_t merge_line;
    cache_pkg::line_t wr_line;

    cache_array #(
        .payload_t (cache_pkg::line_t)
    ) data_array_i (
        .clk     (clk),
        .reset   (reset),
        .index   (index),
        .rd_data (rd_lines),
        .we      (fill_we || merge_we),
        .wr_way  (way),
        .wr_data (wr_line)
    );

    assign sel_line = rd_lines[way];

    // Byte merge of the request into the selected line
    always_comb begin
        for (int b = 0; b < `LINE_BYTES; b++) begin
            merge_line[b*8 +: 8] = req_mask[b] ? req_data[b*8 +: 8] : sel_line[b*8 +: 8];
        end
    end

    assign wr_line = fill_we ? fill_line : merge_line;

    // Response line for the cycle after acceptance
    always_ff @(posedge clk) begin
        merged_line <= merge_we ? merge_line : sel_line;
    end

    // Fills only land while the requester is stalled
    a_one_writer: assert property (@(posedge clk) disable iff (reset)
        !(fill_we && merge_we));

endmodule

`default_nettype wire

//--- design/meta_store.sv
`timescale 1ns/100ps
`default_nettype none

`include "cache_defines.svh"

module meta_store (
    input  wire                      clk,
    input  wire                      reset,
    input  wire cache_pkg::index_t   index,
    input  wire cache_pkg::way_t     way,
    input  wire                      touch,
    input  wire                      install,
    input  wire                      set_dirty,
    output logic [`CACHE_WAYS-1:0]   valid_bits,
    output cache_pkg::way_t          victim_way,
    output logic                     victim_dirty
);

    logic [`CACHE_WAYS-1:0] valid_q [`CACHE_SETS];
    logic [`CACHE_WAYS-1:0] dirty_q [`CACHE_SETS];
    cache_pkg::age_t        age_q   [`CACHE_SETS][`CACHE_WAYS];

    cache_pkg::age_t        old_age;
    logic                   found_invalid;
    logic [`CACHE_WAYS-1:0] age_cover [`CACHE_SETS];

    assign valid_bits = valid_q[index];
    assign old_age    = age_q[index][way];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
                // Ages start equal to the way number
                for (int w = 0; w < `CACHE_WAYS; w++) begin
                    age_q[s][w] <= cache_pkg::age_t'(w);
                end
            end
        end else begin
            if (touch || install) begin
                for (int w = 0; w < `CACHE_WAYS; w++) begin
                    if (cache_pkg::way_t'(w) == way) begin
                        age_q[index][w] <= '0;
                    end else if (age_q[index][w] < old_age) begin
                        age_q[index][w] <= age_q[index][w] + 1'b1;
                    end
                end
            end
            if (install) begin
                valid_q[index][way] <= 1'b1;
                dirty_q[index][way] <= 1'b0;
            end else if (set_dirty) begin
                dirty_q[index][way] <= 1'b1;
            end
        end
    end

    // Lowest invalid way first, else the oldest
    always_comb begin
        victim_way    = '0;
        found_invalid = 1'b0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (!valid_q[index][w] && !found_invalid) begin
                victim_way    = cache_pkg::way_t'(w);
                found_invalid = 1'b1;
            end
        end
        if (!found_invalid) begin
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                if (age_q[index][w] == cache_pkg::age_t'(`CACHE_WAYS - 1)) begin
                    victim_way = cache_pkg::way_t'(w);
                end
            end
        end
    end

    assign victim_dirty = valid_q[index][victim_way] && dirty_q[index][victim_way];

    // One way per age value in every set
    always_comb begin
        for (int s = 0; s < `CACHE_SETS; s++) begin
            age_cover[s] = '0;
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                age_cover[s][age_q[s][w]] = 1'b1;
            end
        end
    end

    for (genvar s = 0; s < `CACHE_SETS; s++) begin : g_age_check
        a_ages_distinct: assert property (@(posedge clk) disable iff (reset)
            &age_cover[s]);
    end

endmodule

`default_nettype wire

//--- design/miss_controller.sv
`timescale 1ns/100ps
`default_nettype none

`include "cache_defines.svh"

module miss_controller (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      req_valid,
    input  wire                      req_write,
    input  wire [`CACHE_WAYS-1:0]    hit_vec,
    input  wire cache_pkg::way_t     victim_way,
    input  wire                      victim_dirty,
    input  wire                      fill_valid,
    output logic                     stall,
    output logic                     accept,
    output logic                     resp_valid,
    output logic                     resp_hit,
    output logic                     wb_valid,
    output logic                     fill_req,
    output logic                     timer_start,
    output logic                     tag_we,
    output logic                     fill_we,
    output logic                     merge_we,
    output logic                     touch,
    output logic                     install,
    output logic                     set_dirty,
    output cache_pkg::way_t          sel_way
);

    typedef enum logic [2:0] {
        S_LOOKUP,
        S_WRITEBACK,
        S_FILL_REQ,
        S_FILL_WAIT,
        S_REPLAY
    } state_t;

    state_t          state_q;
    state_t          state_d;
    logic            hit;
    cache_pkg::way_t hit_way;

    assign hit = |hit_vec;

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (hit_vec[w]) begin
                hit_way = cache_pkg::way_t'(w);
            end
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_LOOKUP: begin
                if (req_valid && !hit) begin
                    state_d = victim_dirty ? S_WRITEBACK : S_FILL_REQ;
                end
            end
            S_WRITEBACK: state_d = S_FILL_REQ;
            S_FILL_REQ:  state_d = S_FILL_WAIT;
            // Keeps waiting past a timeout
            S_FILL_WAIT: begin
                if (fill_valid) begin
                    state_d = S_REPLAY;
                end
            end
            S_REPLAY:    state_d = S_LOOKUP;
            default:     state_d = S_LOOKUP;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q    <= S_LOOKUP;
            resp_valid <= 1'b0;
            resp_hit   <= 1'b0;
        end else begin
            state_q    <= state_d;
            resp_valid <= accept;
            // Replayed requests report a miss
            resp_hit   <= accept && (state_q == S_LOOKUP);
        end
    end

    // Stall from the miss cycle through the fill, released for replay
    assign stall = (state_q == S_LOOKUP) ? (req_valid && !hit) : (state_q != S_REPLAY);
    assign accept = req_valid && !stall;

    assign wb_valid    = (state_q == S_WRITEBACK);
    assign fill_req    = (state_q == S_FILL_REQ);
    assign timer_start = fill_req;

    assign install = (state_q == S_FILL_WAIT) && fill_valid;
    assign tag_we  = install;
    assign fill_we = install;

    assign touch     = accept;
    assign merge_we  = accept && req_write;
    assign set_dirty = merge_we;

    // Hit way for accesses, victim way during a miss
    assign sel_way = (state_q == S_LOOKUP || state_q == S_REPLAY) ? hit_way : victim_way;

    // Fills arrive only for an outstanding request
    a_fill_expected: assert property (@(posedge clk) disable iff (reset)
        fill_valid |-> (state_q == S_FILL_WAIT));

endmodule

`default_nettype wire

//--- design/tag_store.sv
`timescale 1ns/100ps
`default_nettype none

`include "cache_defines.svh"

module tag_store (
    input  wire                      clk,
    input  wire                      reset,
    input  wire cache_pkg::index_t   index,
    input  wire cache_pkg::tag_t     req_tag,
    input  wire [`CACHE_WAYS-1:0]    valid_bits,
    input  wire                      we,
    input  wire cache_pkg::way_t     wr_way,
    output logic [`CACHE_WAYS-1:0]   hit_vec,
    output cache_pkg::tag_t          way_tags [`CACHE_WAYS]
);

    // Installs always write the tag of the held request
    cache_array #(
        .payload_t (cache_pkg::tag_t)
    ) tag_array_i (
        .clk     (clk),
        .reset   (reset),
        .index   (index),
        .rd_data (way_tags),
        .we      (we),
        .wr_way  (wr_way),
        .wr_data (req_tag)
    );

    always_comb begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            hit_vec[w] = valid_bits[w] && (way_tags[w] == req_tag);
        end
    end

    // Only a miss installs, so a tag never lives in two ways of a set
    a_hit_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(hit_vec));

endmodule

`default_nettype wire
